/* rtl/dproc_pkg.sv */
// Encodings and stage payloads for the integer execute path
// Branch targets are not computed here, the offset only travels with the taken flag
`default_nettype none

package dproc_pkg;

  // Data path width
  localparam int xlen = 32;

  // ALU function select
  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_XOR   = 3'd1,
    ALU_OR    = 3'd2,
    ALU_AND   = 3'd3,
    ALU_SLT   = 3'd4,
    ALU_SLTU  = 3'd5,
    ALU_SHIFT = 3'd6
  } alu_op_e;

  // Branch comparison select
  typedef enum logic [2:0] {
    BR_EQ  = 3'd0,
    BR_NE  = 3'd1,
    BR_LT  = 3'd2,
    BR_GE  = 3'd3,
    BR_LTU = 3'd4,
    BR_GEU = 3'd5
  } branch_cond_e;

  // Decoded instruction as it arrives at issue
  typedef struct packed {
    alu_op_e           alu_op;
    logic              sub;
    logic              shift_right;
    logic              shift_arith;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic              use_imm;
    logic [xlen-1:0]   imm;
    logic [4:0]        rd;
    logic              write;
    logic              branch;
    branch_cond_e      branch_cond;
    logic [19:0]       branch_offset;
  } issue_req_t;

  // Instruction with operands resolved from the register file
  typedef struct packed {
    logic [xlen-1:0]   operand1;
    logic [xlen-1:0]   operand2;
    alu_op_e           alu_op;
    logic              sub;
    logic              shift_right;
    logic              shift_arith;
    logic              branch;
    branch_cond_e      branch_cond;
    logic [19:0]       branch_offset;
    logic [4:0]        rd;
    logic              write;
  } exec_req_t;

  // Retired result
  typedef struct packed {
    logic              write;
    logic [4:0]        rd;
    logic [xlen-1:0]   result;
    logic              branch_taken;
    logic [19:0]       branch_offset;
  } exec_rsp_t;

endpackage

`default_nettype wire

/* rtl/regfile.sv */
// 32 x 32-bit register file, two asynchronous reads and one write
// Register 0 always reads zero, writes to it are dropped
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire logic                      clk_i,
  input  wire logic                      arst_n_i,
  // Read ports
  input  wire logic [4:0]                rs1_addr_i,
  input  wire logic [4:0]                rs2_addr_i,
  output logic [dproc_pkg::xlen-1:0]     rs1_data_o,
  output logic [dproc_pkg::xlen-1:0]     rs2_data_o,
  // Write port
  input  wire logic                      we_i,
  input  wire logic [4:0]                waddr_i,
  input  wire logic [dproc_pkg::xlen-1:0] wdata_i
);

  // Only registers 1 to 31 are storage
  logic [dproc_pkg::xlen-1:0] regs_q [31:1];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != 5'd0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Address 0 bypasses the array
  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

/* rtl/issue_stage.sv */
// Issue with a pending-write scoreboard and no forwarding
// A dependent instruction stalls until its producer retires
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  wire logic                       clk_i,
  input  wire logic                       arst_n_i,
  // Decoded instruction in
  input  wire logic                       in_valid_i,
  output logic                            in_ready_o,
  input  wire dproc_pkg::issue_req_t      in_i,
  // Register file read
  output logic [4:0]                      rs1_addr_o,
  output logic [4:0]                      rs2_addr_o,
  input  wire logic [dproc_pkg::xlen-1:0] rs1_data_i,
  input  wire logic [dproc_pkg::xlen-1:0] rs2_data_i,
  // Request to execute
  output logic                            out_valid_o,
  input  wire logic                       out_ready_i,
  output dproc_pkg::exec_req_t            out_o,
  // Retire event from the end of execute
  input  wire logic                       retire_i,
  input  wire logic [4:0]                 retire_rd_i,
  input  wire logic                       retire_write_i
);

  logic [31:0] pending_q;
  logic [31:0] pending_d;
  logic        hazard;
  logic        fire;

  assign rs1_addr_o = in_i.rs1;
  assign rs2_addr_o = in_i.rs2;

  // Both sources checked even with an immediate, kept conservative
  // A pending rd keeps two writes to one register from overlapping
  assign hazard = pending_q[in_i.rs1] | pending_q[in_i.rs2] |
                  (in_i.write & pending_q[in_i.rd]);

  assign out_valid_o = in_valid_i & ~hazard;
  assign in_ready_o  = out_ready_i & ~hazard;
  assign fire        = in_valid_i & in_ready_o;

  // Operand resolution
  always_comb begin
    out_o.operand1      = rs1_data_i;
    out_o.operand2      = in_i.use_imm ? in_i.imm : rs2_data_i;
    out_o.alu_op        = in_i.alu_op;
    out_o.sub           = in_i.sub;
    out_o.shift_right   = in_i.shift_right;
    out_o.shift_arith   = in_i.shift_arith;
    out_o.branch        = in_i.branch;
    out_o.branch_cond   = in_i.branch_cond;
    out_o.branch_offset = in_i.branch_offset;
    out_o.rd            = in_i.rd;
    out_o.write         = in_i.write;
  end

  // Clear on retire, set on forward of a writer
  always_comb begin
    pending_d = pending_q;
    if (retire_i && retire_write_i) begin
      pending_d[retire_rd_i] = 1'b0;
    end
    // x0 never becomes pending
    if (fire && in_i.write && (in_i.rd != 5'd0)) begin
      pending_d[in_i.rd] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= '0;
    end else begin
      pending_q <= pending_d;
    end
  end

endmodule

`default_nettype wire

/* rtl/pipe_reg.sv */
// One-entry valid/ready register, payload type set by the parent
// Full throughput when downstream stays ready, one cycle of latency
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk_i,
  input  wire logic     arst_n_i,
  // Upstream side
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  input  wire payload_t in_i,
  // Downstream side
  output logic          out_valid_o,
  input  wire logic     out_ready_i,
  output payload_t      out_o
);

  logic     valid_q;
  payload_t data_q;

  // Accept when empty or draining this cycle
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_o       = data_q;

endmodule

`default_nettype wire

/* rtl/alu.sv */
// Combinational ALU and branch compare
// Shift amount is operand2[4:0], right shifts reuse the left shifter
`timescale 1ns/1ps
`default_nettype none

module alu (
  input  wire dproc_pkg::exec_req_t req_i,
  output dproc_pkg::exec_rsp_t      rsp_o
);

  logic [dproc_pkg::xlen-1:0] op1;
  logic [dproc_pkg::xlen-1:0] op2;
  logic [dproc_pkg::xlen-1:0] sum;
  logic                       lt;
  logic                       ltu;
  logic                       eq;
  logic                       fill;
  logic [dproc_pkg::xlen-1:0] shift_in;
  logic [dproc_pkg::xlen-1:0] sh0, sh1, sh2, sh3, sh4;
  logic [dproc_pkg::xlen-1:0] shift_out;
  logic [dproc_pkg::xlen-1:0] result;
  logic                       cond;

  assign op1 = req_i.operand1;
  assign op2 = req_i.operand2;

  // Two's complement subtract through the same adder
  assign sum = op1 + (req_i.sub ? (~op2 + 1'b1) : op2);

  assign eq  = (op1 == op2);
  assign lt  = ($signed(op1) < $signed(op2));
  assign ltu = (op1 < op2);

  // Sign fill only for arithmetic right shift
  assign fill     = req_i.shift_right & req_i.shift_arith & op1[31];
  assign shift_in = req_i.shift_right ? {<<{op1}} : op1;

  // Barrel stages, left shift with fill
  assign sh0 = op2[0] ? {shift_in[30:0], {1{fill}}} : shift_in;
  assign sh1 = op2[1] ? {sh0[29:0], {2{fill}}}      : sh0;
  assign sh2 = op2[2] ? {sh1[27:0], {4{fill}}}      : sh1;
  assign sh3 = op2[3] ? {sh2[23:0], {8{fill}}}      : sh2;
  assign sh4 = op2[4] ? {sh3[15:0], {16{fill}}}     : sh3;

  assign shift_out = req_i.shift_right ? {<<{sh4}} : sh4;

  always_comb begin
    case (req_i.alu_op)
      dproc_pkg::ALU_ADD:   result = sum;
      dproc_pkg::ALU_XOR:   result = op1 ^ op2;
      dproc_pkg::ALU_OR:    result = op1 | op2;
      dproc_pkg::ALU_AND:   result = op1 & op2;
      dproc_pkg::ALU_SLT:   result = {31'd0, lt};
      dproc_pkg::ALU_SLTU:  result = {31'd0, ltu};
      dproc_pkg::ALU_SHIFT: result = shift_out;
      default:              result = '0;
    endcase
  end

  always_comb begin
    case (req_i.branch_cond)
      dproc_pkg::BR_EQ:  cond = eq;
      dproc_pkg::BR_NE:  cond = ~eq;
      dproc_pkg::BR_LT:  cond = lt;
      dproc_pkg::BR_GE:  cond = ~lt;
      dproc_pkg::BR_LTU: cond = ltu;
      dproc_pkg::BR_GEU: cond = ~ltu;
      default:           cond = 1'b0;
    endcase
  end

  assign rsp_o.write         = req_i.write;
  assign rsp_o.rd            = req_i.rd;
  assign rsp_o.result        = result;
  assign rsp_o.branch_taken  = req_i.branch & cond;
  assign rsp_o.branch_offset = req_i.branch_offset;

endmodule

`default_nettype wire

/* rtl/exec_stage.sv */
// Execute stage, operand register then ALU then result register
// Two cycles of latency, at most two instructions in flight
`timescale 1ns/1ps
`default_nettype none

module exec_stage (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  // Request from issue
  input  wire logic                 in_valid_i,
  output logic                      in_ready_o,
  input  wire dproc_pkg::exec_req_t in_i,
  // Result towards retire
  output logic                      out_valid_o,
  input  wire logic                 out_ready_i,
  output dproc_pkg::exec_rsp_t      out_o
);

  // Registered operands
  logic                 req_valid;
  logic                 req_ready;
  dproc_pkg::exec_req_t req_q;

  // ALU output before the result register
  dproc_pkg::exec_rsp_t alu_rsp;

  pipe_reg #(
    .payload_t (dproc_pkg::exec_req_t)
  ) u_in_reg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_i        (in_i),
    .out_valid_o (req_valid),
    .out_ready_i (req_ready),
    .out_o       (req_q)
  );

  alu u_alu (
    .req_i (req_q),
    .rsp_o (alu_rsp)
  );

  // Handshake passes straight through the combinational ALU
  pipe_reg #(
    .payload_t (dproc_pkg::exec_rsp_t)
  ) u_out_reg (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (req_valid),
    .in_ready_o  (req_ready),
    .in_i        (alu_rsp),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_o       (out_o)
  );

endmodule

`default_nettype wire

/* rtl/exec_core.sv */
// Integer execute subsystem top, issue plus register file plus execute
// No forwarding, results are written back on the retire handshake
`timescale 1ns/1ps
`default_nettype none

module exec_core (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  // Decoded instruction port
  input  wire logic                  issue_valid_i,
  output logic                       issue_ready_o,
  input  wire dproc_pkg::issue_req_t issue_i,
  // Retire port
  output logic                       res_valid_o,
  input  wire logic                  res_ready_i,
  output dproc_pkg::exec_rsp_t       res_o
);

  logic [4:0]                 rs1_addr;
  logic [4:0]                 rs2_addr;
  logic [dproc_pkg::xlen-1:0] rs1_data;
  logic [dproc_pkg::xlen-1:0] rs2_data;
  logic                       ex_valid;
  logic                       ex_ready;
  dproc_pkg::exec_req_t       ex_req;
  logic                       retire;

  assign retire = res_valid_o & res_ready_i;

  issue_stage u_issue (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .in_valid_i     (issue_valid_i),
    .in_ready_o     (issue_ready_o),
    .in_i           (issue_i),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .out_valid_o    (ex_valid),
    .out_ready_i    (ex_ready),
    .out_o          (ex_req),
    .retire_i       (retire),
    .retire_rd_i    (res_o.rd),
    .retire_write_i (res_o.write)
  );

  regfile u_regfile (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (retire & res_o.write),
    .waddr_i    (res_o.rd),
    .wdata_i    (res_o.result)
  );

  exec_stage u_exec (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (ex_valid),
    .in_ready_o  (ex_ready),
    .in_i        (ex_req),
    .out_valid_o (res_valid_o),
    .out_ready_i (res_ready_i),
    .out_o       (res_o)
  );

endmodule

`default_nettype wire

/* test/exec_core_assert.sv */
// Handshake and scoreboard assertions, bound into exec_core
// Assumes the scoreboard register inside u_issue is named pending_q
`timescale 1ns/1ps
`default_nettype none

module exec_core_assert (
  input wire logic                  clk_i,
  input wire logic                  arst_n_i,
  input wire logic                  issue_valid_i,
  input wire logic                  issue_ready_i,
  input wire dproc_pkg::issue_req_t issue_i,
  input wire logic                  res_valid_i,
  input wire logic                  res_ready_i,
  input wire dproc_pkg::exec_rsp_t  res_i,
  input wire logic [31:0]           pending_i
);

  int fail_count = 0;

  // Stalled result keeps valid and payload
  res_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(res_i))
    else begin
      fail_count++;
      $error("res_valid_o or res_o changed while stalled");
    end

  handshake_known_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(issue_ready_i) && !$isunknown(res_valid_i))
    else begin
      fail_count++;
      $error("issue_ready_o or res_valid_o is unknown");
    end

  // Sources must not be in flight when issued
  no_hazard_issue_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    issue_valid_i && issue_ready_i |-> !pending_i[issue_i.rs1] && !pending_i[issue_i.rs2])
    else begin
      fail_count++;
      $error("issue accepted with a pending source register");
    end

endmodule

bind exec_core exec_core_assert u_assert (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .issue_valid_i (issue_valid_i),
  .issue_ready_i (issue_ready_o),
  .issue_i       (issue_i),
  .res_valid_i   (res_valid_o),
  .res_ready_i   (res_ready_i),
  .res_i         (res_o),
  .pending_i     (u_issue.pending_q)
);

`default_nettype wire

/* test/exec_core_tb.sv */
// Random instruction testbench for exec_core with a mirror register file model
// Register fields limited to x0..x7 so scoreboard stalls happen often
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

  localparam int clk_period   = 4;
  localparam int n_directed   = 7;
  localparam int n_random     = 400;
  localparam int total_instr  = n_directed + n_random;
  localparam int watchdog_cyc = total_instr * 20;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  issue_valid_i;
  logic                  issue_ready_o;
  dproc_pkg::issue_req_t issue_i;
  logic                  res_valid_o;
  logic                  res_ready_i;
  dproc_pkg::exec_rsp_t  res_o;

  logic [15:0]           lfsr_q;
  logic [31:0]           mirror [32];
  dproc_pkg::exec_rsp_t  expect_q [$];
  dproc_pkg::exec_rsp_t  exp_rsp;
  int                    errors;
  int                    offered;
  int                    retired;
  logic                  accepted;

  exec_core DUT (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_ready_o (issue_ready_o),
    .issue_i       (issue_i),
    .res_valid_o   (res_valid_o),
    .res_ready_i   (res_ready_i),
    .res_o         (res_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[FAIL] t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    end
  endtask

  // A register is in flight while an outstanding result still writes it
  function automatic logic writer_pending(input logic [4:0] r);
    logic hit;
    hit = 1'b0;
    foreach (expect_q[i]) begin
      if (expect_q[i].write && expect_q[i].rd == r && r != 5'd0) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  // Sources or a written destination still in flight
  function automatic logic has_hazard(input dproc_pkg::issue_req_t ins);
    return writer_pending(ins.rs1) || writer_pending(ins.rs2) ||
           (ins.write && writer_pending(ins.rd));
  endfunction

  // First few add x0 to x1..x7, all zero straight after reset
  function automatic dproc_pkg::issue_req_t make_instr(input int idx);
    dproc_pkg::issue_req_t ins;
    ins = '0;
    if (idx < n_directed) begin
      ins.alu_op = dproc_pkg::ALU_ADD;
      ins.rs2    = 5'(idx + 1);
      ins.write  = 1'b1;
      return ins;
    end
    ins.alu_op        = dproc_pkg::alu_op_e'(3'(rand_bits(3) % 7));
    ins.sub           = 1'(rand_bits(1));
    ins.shift_right   = 1'(rand_bits(1));
    ins.shift_arith   = 1'(rand_bits(1));
    ins.rs1           = 5'(rand_bits(3));
    ins.rs2           = 5'(rand_bits(3));
    ins.use_imm       = 1'(rand_bits(1));
    ins.imm           = rand_bits(32);
    ins.rd            = 5'(rand_bits(3));
    ins.write         = (rand_bits(2) != 0);
    ins.branch        = (rand_bits(2) == 0);
    ins.branch_cond   = dproc_pkg::branch_cond_e'(3'(rand_bits(3) % 6));
    ins.branch_offset = 20'(rand_bits(20));
    return ins;
  endfunction

  // Expected retirement, operands taken from the mirror
  function automatic dproc_pkg::exec_rsp_t predict(input dproc_pkg::issue_req_t ins);
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          res;
    logic                 taken;
    dproc_pkg::exec_rsp_t rsp;
    a = mirror[ins.rs1];
    b = ins.use_imm ? ins.imm : mirror[ins.rs2];
    case (ins.alu_op)
      dproc_pkg::ALU_ADD:  res = ins.sub ? a - b : a + b;
      dproc_pkg::ALU_XOR:  res = a ^ b;
      dproc_pkg::ALU_OR:   res = a | b;
      dproc_pkg::ALU_AND:  res = a & b;
      dproc_pkg::ALU_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      dproc_pkg::ALU_SLTU: res = (a < b) ? 32'd1 : 32'd0;
      default: begin
        if (!ins.shift_right) res = a << b[4:0];
        else if (ins.shift_arith) res = $unsigned($signed(a) >>> b[4:0]);
        else res = a >> b[4:0];
      end
    endcase
    case (ins.branch_cond)
      dproc_pkg::BR_EQ:  taken = (a == b);
      dproc_pkg::BR_NE:  taken = (a != b);
      dproc_pkg::BR_LT:  taken = ($signed(a) < $signed(b));
      dproc_pkg::BR_GE:  taken = ($signed(a) >= $signed(b));
      dproc_pkg::BR_LTU: taken = (a < b);
      default:           taken = (a >= b);
    endcase
    rsp.write         = ins.write;
    rsp.rd            = ins.rd;
    rsp.result        = res;
    rsp.branch_taken  = ins.branch & taken;
    rsp.branch_offset = ins.branch_offset;
    return rsp;
  endfunction

  initial begin : stimulus
    lfsr_q = 16'd48872;
    errors = 0;
    offered = 0;
    retired = 0;
    for (int i = 0; i < 32; i++) mirror[i] = '0;
    arst_n_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_i = '0;
    res_ready_i = 1'b0;
    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    check_value("res_valid_o", 32'd0, 32'(res_valid_o));
    // Empty pipeline and clear scoreboard
    check_value("issue_ready_o", 32'd1, 32'(issue_ready_o));
    while (retired < total_instr) begin
      @(posedge clk_i);
      // Outstanding queue still matches the scoreboard before this edge
      if (issue_valid_i && has_hazard(issue_i)) begin
        check_value("issue_ready_o", 32'd0, 32'(issue_ready_o));
      end
      // Sample the handshakes of this edge before driving the next cycle
      accepted = issue_valid_i && issue_ready_o;
      if (accepted) begin
        exp_rsp = predict(issue_i);
        expect_q.push_back(exp_rsp);
        // In-order retirement lets the mirror update right away
        if (issue_i.write && issue_i.rd != 5'd0) mirror[issue_i.rd] = exp_rsp.result;
      end
      if (res_valid_o && res_ready_i) begin
        retired++;
        if (expect_q.size() == 0) begin
          errors++;
          $display("ERROR t=%0t result retired with nothing outstanding", $time);
        end else begin
          exp_rsp = expect_q.pop_front();
          check_value("res_o.write", 32'(exp_rsp.write), 32'(res_o.write));
          check_value("res_o.rd", 32'(exp_rsp.rd), 32'(res_o.rd));
          check_value("res_o.result", exp_rsp.result, res_o.result);
          check_value("res_o.branch_taken", 32'(exp_rsp.branch_taken), 32'(res_o.branch_taken));
          check_value("res_o.branch_offset", 32'(exp_rsp.branch_offset),
                      32'(res_o.branch_offset));
        end
      end
      // A raised valid holds until it is taken
      if (!issue_valid_i || accepted) begin
        if (offered < total_instr && rand_bits(2) != 0) begin
          issue_i <= make_instr(offered);
          issue_valid_i <= 1'b1;
          offered++;
        end else begin
          issue_valid_i <= 1'b0;
        end
      end
      res_ready_i <= (rand_bits(2) != 0);
    end
    // Drain window, nothing may retire any more
    issue_valid_i <= 1'b0;
    res_ready_i <= 1'b1;
    repeat (10) begin
      @(posedge clk_i);
      if (res_valid_o && res_ready_i) begin
        errors++;
        $display("ERROR t=%0t extra result retired after all instructions", $time);
      end
    end
    if (expect_q.size() != 0) begin
      errors++;
      $display("ERROR %0d expected results never retired", expect_q.size());
    end
    errors += DUT.u_assert.fail_count;
    $display("Summary: %0d of %0d retired, %0d errors", retired, total_instr, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(watchdog_cyc * clk_period);
    $display("Watchdog expired after %0d cycles with %0d of %0d retired, %0d errors",
             watchdog_cyc, retired, total_instr, errors);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
rtl/dproc_pkg.sv
rtl/regfile.sv
rtl/issue_stage.sv
rtl/pipe_reg.sv
rtl/alu.sv
rtl/exec_stage.sv
rtl/exec_core.sv
test/exec_core_assert.sv
test/exec_core_tb.sv
